/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // byte address width seen by the cpu and the memory
  localparam int ADDR_W = 32;

  // one memory beat, also the cpu word
  localparam int BEAT_W = 64;

  // beats per cache line
  localparam int BEATS = 8;

  // full line, 64 bytes
  localparam int LINE_W = BEAT_W * BEATS;

  // byte offset inside a line
  localparam int OFFSET_W = 6;

  // direct mapped, one line per set
  localparam int SETS = 16;
  localparam int INDEX_W = 4;

  // whatever is left above index and offset
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // line operation codes
  localparam logic OP_READ = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  // beat size code, 8 bytes per beat
  localparam logic [2:0] SIZE_D = 3'd3;

  // burst length code, beats minus one
  localparam logic [7:0] BLKS_LINE = 8'd7;

endpackage

`default_nettype wire

/* design/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
  input  wire                            clk,
  input  wire                            rst,
  // cpu side level request held until ack
  input  wire                            i_cpu_req,
  input  wire                            i_cpu_we,
  input  wire  [cache_pkg::ADDR_W-1:0]   i_cpu_addr,
  input  wire  [cache_pkg::BEAT_W-1:0]   i_cpu_wdata,
  input  wire  [cache_pkg::BEAT_W/8-1:0] i_cpu_wstrb,
  output logic [cache_pkg::BEAT_W-1:0]   o_cpu_rdata,
  output logic                           o_cpu_ack,
  // whole line request to the transfer unit
  output logic                           o_xfer_req,
  output logic                           o_xfer_op,
  output logic [cache_pkg::ADDR_W-1:0]   o_xfer_addr,
  output logic [cache_pkg::LINE_W-1:0]   o_xfer_wdata,
  input  wire                            i_xfer_ack,
  input  wire  [cache_pkg::LINE_W-1:0]   i_xfer_rdata
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL,
    ST_RESPOND
  } state_t;

  state_t state;

  // cache arrays
  logic [cache_pkg::TAG_W-1:0]  tag_mem  [cache_pkg::SETS];
  logic [cache_pkg::LINE_W-1:0] data_mem [cache_pkg::SETS];
  logic [cache_pkg::SETS-1:0]   valid_bits;
  logic [cache_pkg::SETS-1:0]   dirty_bits;

  // registered cpu access
  logic [cache_pkg::ADDR_W-1:0]   req_addr;
  logic                           req_we;
  logic [cache_pkg::BEAT_W-1:0]   req_wdata;
  logic [cache_pkg::BEAT_W/8-1:0] req_wstrb;

  // address fields of the registered access
  logic [cache_pkg::TAG_W-1:0]          req_tag;
  logic [cache_pkg::INDEX_W-1:0]        req_idx;
  logic [$clog2(cache_pkg::BEATS)-1:0]  word_sel;

  logic [cache_pkg::LINE_W-1:0] cur_line;
  logic [cache_pkg::LINE_W-1:0] merged_line;
  logic                         hit;
  logic                         start_wb;
  logic                         fill_raise;
  logic                         fill_done;

  assign req_tag  = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_idx  = req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign word_sel = req_addr[cache_pkg::OFFSET_W-1 -: $clog2(cache_pkg::BEATS)];

  // line at the registered index
  assign cur_line = data_mem[req_idx];

  // tag compare against the one set
  assign hit = valid_bits[req_idx] && (tag_mem[req_idx] == req_tag);

  // dirty victim needs a write back before the refill
  assign start_wb = (state == ST_LOOKUP) && !hit && dirty_bits[req_idx];

  // refill request goes up one cycle after entering refill
  assign fill_raise = (state == ST_REFILL) && !o_xfer_req;
  assign fill_done  = (state == ST_REFILL) && o_xfer_req && i_xfer_ack;

  // only strobed bytes of the selected word change
  always_comb begin
    merged_line = cur_line;
    for (int b = 0; b < cache_pkg::BEAT_W / 8; b++) begin
      if (req_wstrb[b]) begin
        merged_line[word_sel*cache_pkg::BEAT_W + b*8 +: 8] = req_wdata[b*8 +: 8];
      end
    end
  end

  // ack only in the respond state
  assign o_cpu_ack = (state == ST_RESPOND);

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      valid_bits <= '0;
      dirty_bits <= '0;
      o_xfer_req <= 1'b0;
      o_xfer_op  <= cache_pkg::OP_READ;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_cpu_req) begin
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            state <= ST_RESPOND;
            if (req_we) begin
              dirty_bits[req_idx] <= 1'b1;
            end
          end else if (dirty_bits[req_idx]) begin
            // victim goes out first
            state      <= ST_WRITEBACK;
            o_xfer_req <= 1'b1;
            o_xfer_op  <= cache_pkg::OP_WRITE;
          end else begin
            state <= ST_REFILL;
          end
        end
        ST_WRITEBACK: begin
          // drop req in the ack cycle and keep it low for one cycle before refill
          if (i_xfer_ack) begin
            o_xfer_req <= 1'b0;
            state      <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (fill_raise) begin
            o_xfer_req <= 1'b1;
            o_xfer_op  <= cache_pkg::OP_READ;
          end else if (fill_done) begin
            o_xfer_req          <= 1'b0;
            valid_bits[req_idx] <= 1'b1;
            dirty_bits[req_idx] <= 1'b0;
            // replay the access which hits this time
            state               <= ST_LOOKUP;
          end
        end
        ST_RESPOND: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // arrays and payload registers
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && i_cpu_req) begin
      req_addr  <= i_cpu_addr;
      req_we    <= i_cpu_we;
      req_wdata <= i_cpu_wdata;
      req_wstrb <= i_cpu_wstrb;
    end
    if (state == ST_LOOKUP && hit) begin
      // loads see the word and stores get the old word back
      o_cpu_rdata <= cur_line[word_sel*cache_pkg::BEAT_W +: cache_pkg::BEAT_W];
      if (req_we) begin
        data_mem[req_idx] <= merged_line;
      end
    end
    if (start_wb) begin
      // victim address from the stored tag
      o_xfer_addr  <= {tag_mem[req_idx], req_idx, {cache_pkg::OFFSET_W{1'b0}}};
      o_xfer_wdata <= cur_line;
    end
    if (fill_raise) begin
      o_xfer_addr <= {req_tag, req_idx, {cache_pkg::OFFSET_W{1'b0}}};
    end
    if (fill_done) begin
      data_mem[req_idx] <= i_xfer_rdata;
      tag_mem[req_idx]  <= req_tag;
    end
  end

  // one ack per access and only while the cpu still holds its request
  a_ack_single: assert property (
    @(posedge clk) disable iff (rst) o_cpu_ack |-> i_cpu_req && !$past(o_cpu_ack)
  );

endmodule

`default_nettype wire

/* design/cache_line_xfer.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_line_xfer (
  input  wire                                  clk,
  input  wire                                  rst,
  // held line request from the controller
  input  wire                                  i_xfer_req,
  input  wire                                  i_xfer_op,
  input  wire  [cache_pkg::ADDR_W-1:0]         i_xfer_addr,
  input  wire  [cache_pkg::LINE_W-1:0]         i_xfer_wdata,
  output logic [cache_pkg::LINE_W-1:0]         o_xfer_rdata,
  output logic                                 o_xfer_ack,
  // valid/ready line transaction
  output logic                                 o_line_valid,
  output logic                                 o_line_op,
  output logic [cache_pkg::ADDR_W-1:0]         o_line_addr,
  output logic [cache_pkg::LINE_W-1:0]         o_line_wdata,
  output logic [$bits(cache_pkg::SIZE_D)-1:0]  o_line_size,
  output logic [$bits(cache_pkg::BLKS_LINE)-1:0] o_line_blks,
  input  wire                                  i_line_ready,
  input  wire  [cache_pkg::LINE_W-1:0]         i_line_rdata
);

  // req seen last cycle
  logic req_his;
  logic line_hs;
  logic xfer_start;

  assign line_hs = o_line_valid & i_line_ready;

  // two high samples in a row and never while busy or acking
  assign xfer_start = i_xfer_req & req_his & ~o_line_valid & ~o_xfer_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_his      <= 1'b0;
      o_line_valid <= 1'b0;
      o_xfer_ack   <= 1'b0;
    end else begin
      req_his <= i_xfer_req;
      if (line_hs) begin
        // line done so ack pulses next cycle
        o_xfer_ack   <= 1'b1;
        o_line_valid <= 1'b0;
      end else begin
        o_xfer_ack <= 1'b0;
        if (xfer_start) begin
          o_line_valid <= 1'b1;
        end
      end
    end
  end

  // read line captured with ready and shown in the ack cycle
  always_ff @(posedge clk) begin
    if (line_hs) begin
      o_xfer_rdata <= i_line_rdata;
    end
  end

  // fixed beat size and burst length
  assign o_line_size = cache_pkg::SIZE_D;
  assign o_line_blks = cache_pkg::BLKS_LINE;

  // 64 byte aligned base
  assign o_line_addr  = {i_xfer_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                         {cache_pkg::OFFSET_W{1'b0}}};
  assign o_line_op    = i_xfer_op;
  assign o_line_wdata = i_xfer_wdata;

  // valid and the line payload hold until the bridge takes the line
  a_valid_hold: assert property (
    @(posedge clk) disable iff (rst)
    o_line_valid && !i_line_ready |=>
      o_line_valid && $stable(o_line_op) && $stable(o_line_addr) && $stable(o_line_wdata)
  );

endmodule

`default_nettype wire

/* design/cache_burst_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_burst_bridge (
  input  wire                                    clk,
  input  wire                                    rst,
  // line transaction from the transfer unit
  input  wire                                    i_line_valid,
  input  wire                                    i_line_op,
  input  wire  [cache_pkg::ADDR_W-1:0]           i_line_addr,
  input  wire  [cache_pkg::LINE_W-1:0]           i_line_wdata,
  input  wire  [$bits(cache_pkg::SIZE_D)-1:0]    i_line_size,
  input  wire  [$bits(cache_pkg::BLKS_LINE)-1:0] i_line_blks,
  output logic                                   o_line_ready,
  output logic [cache_pkg::LINE_W-1:0]           o_line_rdata,
  // memory beat port
  output logic                                   o_mem_valid,
  output logic                                   o_mem_we,
  output logic [cache_pkg::ADDR_W-1:0]           o_mem_addr,
  output logic [cache_pkg::BEAT_W-1:0]           o_mem_wdata,
  input  wire                                    i_mem_ready,
  input  wire  [cache_pkg::BEAT_W-1:0]           i_mem_rdata
);

  // counter as wide as the burst length code
  logic [$bits(cache_pkg::BLKS_LINE)-1:0] beat_cnt;
  // beat number inside the line
  logic [$clog2(cache_pkg::BEATS)-1:0]    beat_sel;
  logic                                   beat_done;
  logic                                   last_beat;
  logic                                   line_start;

  assign beat_sel  = beat_cnt[$clog2(cache_pkg::BEATS)-1:0];
  assign beat_done = o_mem_valid & i_mem_ready;
  assign last_beat = (beat_cnt == i_line_blks);

  // new line only when idle and not in the ready cycle
  assign line_start = i_line_valid & ~o_mem_valid & ~o_line_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_mem_valid  <= 1'b0;
      o_line_ready <= 1'b0;
      beat_cnt     <= '0;
    end else begin
      o_line_ready <= 1'b0;
      if (line_start) begin
        o_mem_valid <= 1'b1;
        beat_cnt    <= '0;
      end else if (beat_done) begin
        if (last_beat) begin
          // blks+1 beats moved
          o_mem_valid  <= 1'b0;
          o_line_ready <= 1'b1;
        end else begin
          // next beat offered right away
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
    end
  end

  // read beats fill the line lowest first
  always_ff @(posedge clk) begin
    if (beat_done && i_line_op == cache_pkg::OP_READ) begin
      o_line_rdata[beat_sel*cache_pkg::BEAT_W +: cache_pkg::BEAT_W] <= i_mem_rdata;
    end
  end

  // base plus 8 bytes per beat
  // held by the counter and the held line inputs during stalls
  assign o_mem_addr = {i_line_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W], beat_sel,
                       {(cache_pkg::OFFSET_W - $clog2(cache_pkg::BEATS)){1'b0}}};
  assign o_mem_we    = i_line_op;
  assign o_mem_wdata = i_line_wdata[beat_sel*cache_pkg::BEAT_W +: cache_pkg::BEAT_W];

  // only 8 byte beats are supported
  a_size: assert property (
    @(posedge clk) disable iff (rst) i_line_valid |-> i_line_size == cache_pkg::SIZE_D
  );

  // beats only while the line is offered and never past the end of that line
  a_in_line: assert property (
    @(posedge clk) disable iff (rst)
    o_mem_valid |-> i_line_valid && beat_cnt < cache_pkg::BEATS &&
      (o_mem_addr - i_line_addr) < cache_pkg::BEATS * 8
  );

endmodule

`default_nettype wire

/* design/cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_top (
  input  wire                            clk,
  input  wire                            rst,
  // cpu port
  input  wire                            i_cpu_req,
  input  wire                            i_cpu_we,
  input  wire  [cache_pkg::ADDR_W-1:0]   i_cpu_addr,
  input  wire  [cache_pkg::BEAT_W-1:0]   i_cpu_wdata,
  input  wire  [cache_pkg::BEAT_W/8-1:0] i_cpu_wstrb,
  output wire  [cache_pkg::BEAT_W-1:0]   o_cpu_rdata,
  output wire                            o_cpu_ack,
  // memory beat port
  output wire                            o_mem_valid,
  output wire                            o_mem_we,
  output wire  [cache_pkg::ADDR_W-1:0]   o_mem_addr,
  output wire  [cache_pkg::BEAT_W-1:0]   o_mem_wdata,
  input  wire                            i_mem_ready,
  input  wire  [cache_pkg::BEAT_W-1:0]   i_mem_rdata
);

  // controller to transfer unit
  wire                                   xfer_req;
  wire                                   xfer_op;
  wire [cache_pkg::ADDR_W-1:0]           xfer_addr;
  wire [cache_pkg::LINE_W-1:0]           xfer_wdata;
  wire                                   xfer_ack;
  wire [cache_pkg::LINE_W-1:0]           xfer_rdata;

  // transfer unit to bridge
  wire                                   line_valid;
  wire                                   line_op;
  wire [cache_pkg::ADDR_W-1:0]           line_addr;
  wire [cache_pkg::LINE_W-1:0]           line_wdata;
  wire [$bits(cache_pkg::SIZE_D)-1:0]    line_size;
  wire [$bits(cache_pkg::BLKS_LINE)-1:0] line_blks;
  wire                                   line_ready;
  wire [cache_pkg::LINE_W-1:0]           line_rdata;

  cache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_cpu_req    (i_cpu_req),
    .i_cpu_we     (i_cpu_we),
    .i_cpu_addr   (i_cpu_addr),
    .i_cpu_wdata  (i_cpu_wdata),
    .i_cpu_wstrb  (i_cpu_wstrb),
    .o_cpu_rdata  (o_cpu_rdata),
    .o_cpu_ack    (o_cpu_ack),
    .o_xfer_req   (xfer_req),
    .o_xfer_op    (xfer_op),
    .o_xfer_addr  (xfer_addr),
    .o_xfer_wdata (xfer_wdata),
    .i_xfer_ack   (xfer_ack),
    .i_xfer_rdata (xfer_rdata)
  );

  cache_line_xfer u_xfer (
    .clk          (clk),
    .rst          (rst),
    .i_xfer_req   (xfer_req),
    .i_xfer_op    (xfer_op),
    .i_xfer_addr  (xfer_addr),
    .i_xfer_wdata (xfer_wdata),
    .o_xfer_rdata (xfer_rdata),
    .o_xfer_ack   (xfer_ack),
    .o_line_valid (line_valid),
    .o_line_op    (line_op),
    .o_line_addr  (line_addr),
    .o_line_wdata (line_wdata),
    .o_line_size  (line_size),
    .o_line_blks  (line_blks),
    .i_line_ready (line_ready),
    .i_line_rdata (line_rdata)
  );

  cache_burst_bridge u_bridge (
    .clk          (clk),
    .rst          (rst),
    .i_line_valid (line_valid),
    .i_line_op    (line_op),
    .i_line_addr  (line_addr),
    .i_line_wdata (line_wdata),
    .i_line_size  (line_size),
    .i_line_blks  (line_blks),
    .o_line_ready (line_ready),
    .o_line_rdata (line_rdata),
    .o_mem_valid  (o_mem_valid),
    .o_mem_we     (o_mem_we),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rdata  (i_mem_rdata)
  );

endmodule

`default_nettype wire

/* testbench/mem_beat_model.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_beat_model #(
  parameter logic [cache_pkg::ADDR_W-1:0] BASE_ADDR = 32'h0010_0000,
  parameter int                           WORDS     = 2048
) (
  input  wire                          clk,
  input  wire                          rst,
  // beat port as seen from the memory side
  input  wire                          i_valid,
  input  wire                          i_we,
  input  wire  [cache_pkg::ADDR_W-1:0] i_addr,
  input  wire  [cache_pkg::BEAT_W-1:0] i_wdata,
  output logic                         o_ready,
  output logic [cache_pkg::BEAT_W-1:0] o_rdata
);

  logic [cache_pkg::BEAT_W-1:0] mem [WORDS];
  logic [cache_pkg::ADDR_W-1:0] offs;
  logic [$clog2(WORDS)-1:0]     widx;
  int unsigned                  wait_left;

  // word index inside the window
  assign offs = i_addr - BASE_ADDR;
  assign widx = offs[3 +: $clog2(WORDS)];

  // initial word, a fixed function of the full byte address
  function automatic logic [63:0] init_word(input logic [31:0] a);
    return {a ^ 32'h5a3c_96e1, {a[15:0], a[31:16]} + 32'h0f1e_2d3c};
  endfunction

  initial begin
    o_ready   = 1'b0;
    o_rdata   = '0;
    wait_left = 0;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = init_word(BASE_ADDR + i * 8);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      o_ready   <= 1'b0;
      wait_left <= 0;
    end else if (o_ready) begin
      // beat taken at this edge, bridge holds valid until ready
      o_ready <= 1'b0;
      if (i_we) begin
        mem[widx] <= i_wdata;
      end
      // 0 to 3 wait cycles before the next ready
      wait_left <= $urandom % 4;
    end else if (i_valid) begin
      if (wait_left == 0) begin
        o_ready <= 1'b1;
        o_rdata <= mem[widx];
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

  // memory window, bits 13:10 give 16 tags per index
  localparam logic [31:0] BASE     = 32'h0010_0000;
  localparam int          WORDS    = 2048;
  localparam int          TIMEOUT  = 2000;
  localparam int          RAND_OPS = 40;

  logic                           clk;
  logic                           rst;
  logic                           i_cpu_req;
  logic                           i_cpu_we;
  logic [cache_pkg::ADDR_W-1:0]   i_cpu_addr;
  logic [cache_pkg::BEAT_W-1:0]   i_cpu_wdata;
  logic [cache_pkg::BEAT_W/8-1:0] i_cpu_wstrb;
  wire  [cache_pkg::BEAT_W-1:0]   o_cpu_rdata;
  wire                            o_cpu_ack;
  wire                            o_mem_valid;
  wire                            o_mem_we;
  wire  [cache_pkg::ADDR_W-1:0]   o_mem_addr;
  wire  [cache_pkg::BEAT_W-1:0]   o_mem_wdata;
  wire                            i_mem_ready;
  wire  [cache_pkg::BEAT_W-1:0]   i_mem_rdata;

  int errors = 0;
  int checks = 0;
  int tests  = 0;
  int stalls = 0;

  // cpu visible contents
  logic [63:0] shadow [WORDS];

  // beats seen on the memory port during the current access
  logic [31:0] beat_addr_q [$];
  logic        beat_we_q   [$];
  logic [63:0] beat_data_q [$];

  // previous cycle of the beat port, for the hold check
  logic        stall_q = 1'b0;
  logic [31:0] addr_q;
  logic        we_q;
  logic [63:0] wdata_q;

  cache_top UUT (
    .clk         (clk),
    .rst         (rst),
    .i_cpu_req   (i_cpu_req),
    .i_cpu_we    (i_cpu_we),
    .i_cpu_addr  (i_cpu_addr),
    .i_cpu_wdata (i_cpu_wdata),
    .i_cpu_wstrb (i_cpu_wstrb),
    .o_cpu_rdata (o_cpu_rdata),
    .o_cpu_ack   (o_cpu_ack),
    .o_mem_valid (o_mem_valid),
    .o_mem_we    (o_mem_we),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

  mem_beat_model #(.BASE_ADDR(BASE), .WORDS(WORDS)) u_mem (
    .clk     (clk),
    .rst     (rst),
    .i_valid (o_mem_valid),
    .i_we    (o_mem_we),
    .i_addr  (o_mem_addr),
    .i_wdata (o_mem_wdata),
    .o_ready (i_mem_ready),
    .o_rdata (i_mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // same initial pattern as the memory model holds
  function automatic logic [63:0] pattern_word(input logic [31:0] a);
    return {a ^ 32'h5a3c_96e1, {a[15:0], a[31:16]} + 32'h0f1e_2d3c};
  endfunction

  function automatic int word_index(input logic [31:0] a);
    return int'((a - BASE) >> 3);
  endfunction

  // random 8 byte aligned address inside the window
  function automatic logic [31:0] rand_addr();
    return BASE + (($urandom % WORDS) << 3);
  endfunction

  // strobed bytes replaced, the rest kept
  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                              input logic [63:0] new_w,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR time %0t %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    end
  endtask

  // closing counts and final verdict
  task automatic end_run();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // one cpu access, cycles counts from the first req cycle to the ack cycle
  task automatic cpu_access(input logic we, input logic [31:0] addr,
                            input logic [63:0] wdata, input logic [7:0] wstrb,
                            output logic [63:0] rdata, output int cycles);
    beat_addr_q.delete();
    beat_we_q.delete();
    beat_data_q.delete();
    @(posedge clk);
    i_cpu_req   <= 1'b1;
    i_cpu_we    <= we;
    i_cpu_addr  <= addr;
    i_cpu_wdata <= wdata;
    i_cpu_wstrb <= wstrb;
    cycles = 0;
    @(posedge clk);
    while (!o_cpu_ack && cycles < TIMEOUT) begin
      cycles++;
      @(posedge clk);
    end
    if (!o_cpu_ack) begin
      $display("ERROR time %0t no o_cpu_ack for access to %h", $time, addr);
      errors++;
      end_run();
    end else begin
      rdata = o_cpu_rdata;
      i_cpu_req <= 1'b0;
    end
  endtask

  // beat log, values sampled just before the edge
  always @(posedge clk) begin
    if (!rst && o_mem_valid && i_mem_ready) begin
      beat_addr_q.push_back(o_mem_addr);
      beat_we_q.push_back(o_mem_we);
      beat_data_q.push_back(o_mem_wdata);
      check_true((o_mem_addr - BASE) < 32'(WORDS * 8), "beat address outside the model window");
    end
  end

  // beat outputs must hold while stalled
  always @(posedge clk) begin
    if (stall_q) begin
      check_equal("o_mem_valid", o_mem_valid, 1'b1);
      check_equal("o_mem_addr", o_mem_addr, addr_q);
      check_equal("o_mem_we", o_mem_we, we_q);
      check_equal("o_mem_wdata", o_mem_wdata, wdata_q);
    end
    if (!rst && o_mem_valid && !i_mem_ready) begin
      stalls++;
    end
    stall_q <= !rst && o_mem_valid && !i_mem_ready;
    addr_q  <= o_mem_addr;
    we_q    <= o_mem_we;
    wdata_q <= o_mem_wdata;
  end

  initial begin
    logic [63:0] rdata;
    logic [63:0] wd;
    logic [7:0]  ws;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] base1;
    logic [31:0] base2;
    logic        we;
    int          cycles;
    int          err0;
    void'($urandom(32'h92363642));
    rst         = 1'b1;
    i_cpu_req   = 1'b0;
    i_cpu_we    = 1'b0;
    i_cpu_addr  = '0;
    i_cpu_wdata = '0;
    i_cpu_wstrb = '0;
    for (int i = 0; i < WORDS; i++) begin
      shadow[i] = pattern_word(BASE + i * 8);
    end

    // reset, quiet outputs from the first edge on
    err0 = errors;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i > 0) begin
        check_equal("o_cpu_ack", o_cpu_ack, 1'b0);
        check_equal("o_mem_valid", o_mem_valid, 1'b0);
      end
    end
    rst <= 1'b0;
    @(posedge clk);
    check_equal("o_cpu_ack", o_cpu_ack, 1'b0);
    check_equal("o_mem_valid", o_mem_valid, 1'b0);
    report_test("reset", err0);

    // cold load, eight read beats from the line base
    err0  = errors;
    a1    = rand_addr();
    base1 = a1 & ~32'h3f;
    cpu_access(1'b0, a1, '0, '0, rdata, cycles);
    check_equal("o_cpu_rdata", rdata, shadow[word_index(a1)]);
    check_equal("read beat count", beat_addr_q.size(), 8);
    for (int k = 0; k < beat_addr_q.size(); k++) begin
      check_equal("o_mem_addr", beat_addr_q[k], base1 + k * 8);
      check_equal("o_mem_we", beat_we_q[k], 1'b0);
    end
    report_test("read miss and fill", err0);

    // strobed store then reload, neighbor word untouched
    err0 = errors;
    wd   = {$urandom, $urandom};
    ws   = $urandom;
    cpu_access(1'b1, a1, wd, ws, rdata, cycles);
    shadow[word_index(a1)] = merge_bytes(shadow[word_index(a1)], wd, ws);
    cpu_access(1'b0, a1, '0, '0, rdata, cycles);
    check_equal("o_cpu_rdata", rdata, shadow[word_index(a1)]);
    cpu_access(1'b0, a1 ^ 32'h8, '0, '0, rdata, cycles);
    check_equal("o_cpu_rdata", rdata, shadow[word_index(a1 ^ 32'h8)]);
    report_test("store merge", err0);

    // resident line, fixed latency and no beats
    err0 = errors;
    cpu_access(1'b0, a1, '0, '0, rdata, cycles);
    check_equal("o_cpu_rdata", rdata, shadow[word_index(a1)]);
    check_equal("hit latency", cycles, 2);
    check_equal("hit beat count", beat_addr_q.size(), 0);
    report_test("hit latency", err0);

    // same index, other tag, dirty victim goes out first
    err0 = errors;
    wd   = {$urandom, $urandom};
    ws   = $urandom;
    cpu_access(1'b1, a1, wd, ws, rdata, cycles);
    shadow[word_index(a1)] = merge_bytes(shadow[word_index(a1)], wd, ws);
    a2    = a1 ^ (32'h400 << ($urandom % 4));
    base2 = a2 & ~32'h3f;
    cpu_access(1'b0, a2, '0, '0, rdata, cycles);
    check_equal("o_cpu_rdata", rdata, shadow[word_index(a2)]);
    check_equal("evict beat count", beat_addr_q.size(), 16);
    for (int k = 0; k < beat_addr_q.size(); k++) begin
      if (k < 8) begin
        check_equal("o_mem_addr", beat_addr_q[k], base1 + k * 8);
        check_equal("o_mem_we", beat_we_q[k], 1'b1);
        check_equal("o_mem_wdata", beat_data_q[k], shadow[word_index(base1) + k]);
      end else begin
        check_equal("o_mem_addr", beat_addr_q[k], base2 + (k - 8) * 8);
        check_equal("o_mem_we", beat_we_q[k], 1'b0);
      end
    end
    // evicted line comes back from memory with the store in it
    cpu_access(1'b0, a1, '0, '0, rdata, cycles);
    check_equal("o_cpu_rdata", rdata, shadow[word_index(a1)]);
    report_test("dirty eviction", err0);

    // random traffic, hold checks run in the background
    err0 = errors;
    for (int i = 0; i < RAND_OPS; i++) begin
      a1 = rand_addr();
      we = $urandom % 2;
      wd = {$urandom, $urandom};
      ws = $urandom;
      cpu_access(we, a1, wd, ws, rdata, cycles);
      if (we) begin
        shadow[word_index(a1)] = merge_bytes(shadow[word_index(a1)], wd, ws);
      end else begin
        check_equal("o_cpu_rdata", rdata, shadow[word_index(a1)]);
      end
    end
    check_true(stalls > 0, "no memory wait state was seen");
    report_test("back-pressure", err0);

    end_run();
  end

endmodule

`default_nettype wire

/* cache_sys.f */
design/cache_pkg.sv
design/cache_ctrl.sv
design/cache_line_xfer.sv
design/cache_burst_bridge.sv
design/cache_top.sv
testbench/mem_beat_model.sv
testbench/cache_tb.sv
